// ==== sources.f ====
+incdir+.
lock_pkg.sv
key_decoder.sv
code_entry.sv
lockout_timer.sv
buzzer_tone.sv
lock_top.sv
tb_lock.sv

// ==== lock_model.svh ====
`ifndef LOCK_MODEL_SVH
`define LOCK_MODEL_SVH

// expected state, kept in step with every key press
logic [11:0] m_entry;
logic [1:0]  m_count;
logic [1:0]  m_tries;
logic        m_locked;

function automatic int digit_of(input logic [15:0] key);
    int d;
    d = -1;  // not a digit key
    for (int i = 0; i < 10; i++) begin
        if (key == DIGIT_KEYS[i]) begin
            d = i;
        end
    end
    return d;
endfunction

task automatic model_reset();
    m_entry  = DISPLAY_BLANK;
    m_count  = 2'd0;
    m_tries  = 2'd0;
    m_locked = 1'b0;
endtask

task automatic model_key(input logic [15:0] key);
    int d;
    d = digit_of(key);
    if (key == KEY_CLEAR) begin
        model_reset();
    end else if (key == KEY_CANCEL) begin
        m_entry = DISPLAY_BLANK;
        m_count = 2'd0;
    end else if (key == KEY_ENTER) begin
        if (!m_locked && m_entry != DISPLAY_PASS && m_count == 2'd3) begin
            if (m_entry == SECRET_CODE) begin
                m_entry = DISPLAY_PASS;
            end else begin
                m_entry = DISPLAY_BLANK;
                m_count = 2'd0;
                m_tries = m_tries + 2'd1;
                if (m_tries == MAX_TRIES) begin
                    m_locked = 1'b1;
                end
            end
        end
    end else if (d >= 0 && !m_locked && m_entry != DISPLAY_PASS && m_count < 2'd3) begin
        m_entry = {m_entry[7:0], 4'(d)};  // new digit enters on the right
        m_count = m_count + 2'd1;
    end
endtask

`endif

// ==== tb_lock.sv ====
module tb_lock;
    timeunit 1ns;
    timeprecision 100ps;
    import lock_pkg::*;

    logic        clk;
    logic        rst;
    logic [15:0] onehot;
    logic [11:0] display;
    logic [1:0]  digit_count;
    logic [1:0]  tries;
    logic        lock_active;
    logic        buzzer;

    logic [31:0] lfsr;
    int          errors;
    int          tests_failed;
    int          test_start_errors;

    `include "lock_model.svh"

    lock_top UUT (
        .clk(clk), .rst(rst), .onehot(onehot), .display(display),
        .digit_count(digit_count), .tries(tries), .lock_active(lock_active), .buzzer(buzzer)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // galois lfsr stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_state();
        compare("digit_count", digit_count, m_count);
        compare("tries", tries, m_tries);
        if (!m_locked) begin
            compare("display", display, m_entry);
            compare("lock_active", lock_active, 1'b0);
        end else if (display[11:8] != 4'h0 || display[7:0] > 8'h59 || display[3:0] > 4'h9) begin
            $display("lockout display %h is not 0 over BCD seconds", display);
            errors++;
        end
    endtask

    // hold 1 to 4 cycles and release for at least one
    task automatic press_key(input logic [15:0] key);
        int hold;
        int last;
        hold = 1 + int'(rand_bits(2));
        last = hold + 1;
        @(posedge clk);
        onehot <= key;
        model_key(key);
        for (int c = 1; c <= last; c++) begin
            @(posedge clk);
            if (c == hold) begin
                onehot <= KEY_NONE;
            end
            @(negedge clk);
            if (c == 2) begin  // 2 cycles after the press
                check_state();
            end
        end
    endtask

    task automatic press_digit(input int d);
        press_key(DIGIT_KEYS[d]);
    endtask

    task automatic enter_code(input logic [11:0] code);
        press_key(KEY_CANCEL);
        press_digit(code[11:8]);
        press_digit(code[7:4]);
        press_digit(code[3:0]);
        press_key(KEY_ENTER);
    endtask

    task automatic enter_wrong_code();
        logic [11:0] code;
        code = {4'(rand_bits(4) % 10), 4'(rand_bits(4) % 10), 4'(rand_bits(4) % 10)};
        if (code == SECRET_CODE) begin
            code[3:0] = 4'd7;
        end
        enter_code(code);
    endtask

    task automatic wait_lockout_end();
        int waited;
        waited = 0;
        while (lock_active && waited < 70 * int'(SECOND_CYCLES)) begin
            @(negedge clk);
            if (lock_active && (display[7:0] > 8'h59 || display[3:0] > 4'h9)) begin
                $display("lockout seconds %h out of range", display[7:0]);
                errors++;
            end
            waited++;
        end
        if (lock_active) begin
            $display("timeout waiting for lock_active to fall");
            errors++;
        end
        @(negedge clk);  // entry clears one cycle after lock_done
        model_reset();
        check_state();
    endtask

    task automatic check_tone(input string name, input int len);
        int i;
        logic last;
        @(negedge clk);
        last = buzzer;
        for (i = 0; i < len && buzzer == last; i++) begin
            @(negedge clk);
        end
        if (buzzer == last) begin
            $display("%s tone: buzzer never toggled", name);
            errors++;
        end
        repeat (len - i + 20) @(negedge clk);
        for (int k = 0; k < 20; k++) begin
            @(negedge clk);
            if (buzzer !== 1'b0) begin
                $display("%s tone: buzzer not low when idle", name);
                errors++;
                break;
            end
        end
    endtask

    task automatic end_test(input string name);
        if (errors == test_start_errors) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: FAILED, %0d bad checks", name, errors - test_start_errors);
            tests_failed++;
        end
        test_start_errors = errors;
    endtask

    initial begin
        lfsr = 32'h26ee;
        errors = 0;
        tests_failed = 0;
        test_start_errors = 0;
        rst = 1'b1;
        onehot = KEY_NONE;
        model_reset();
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_state();
        compare("buzzer", buzzer, 1'b0);

        for (int i = 0; i < 30; i++) begin
            if (rand_bits(3) == 0) begin
                press_key(KEY_CANCEL);
            end else begin
                press_digit(rand_bits(4) % 10);
            end
        end
        end_test("random_digits");

        enter_code(SECRET_CODE);
        press_digit(rand_bits(4) % 10);  // pass display holds
        press_digit(rand_bits(4) % 10);
        press_key(KEY_CANCEL);
        end_test("correct_code");

        repeat (3) enter_wrong_code();
        compare("display", display, 12'h000);
        @(negedge clk);
        compare("lock_active", lock_active, 1'b1);
        repeat (3) press_digit(rand_bits(4) % 10);
        end_test("failures_lockout");

        wait_lockout_end();
        end_test("lockout_end");

        enter_wrong_code();
        press_digit(rand_bits(4) % 10);
        press_digit(rand_bits(4) % 10);
        press_key(KEY_CLEAR);
        repeat (3) enter_wrong_code();
        @(negedge clk);
        compare("lock_active", lock_active, 1'b1);
        press_key(KEY_CLEAR);
        end_test("clear");

        press_digit(rand_bits(4) % 10);
        check_tone("chirp", CHIRP_LEN);
        enter_code(SECRET_CODE);
        check_tone("pass", PASS_LEN);
        enter_wrong_code();
        check_tone("fail", FAIL_LEN);
        end_test("buzzer");

        $display("6 tests, %0d failed, %0d bad checks in total", tests_failed, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== lock_top.sv ====
module lock_top (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] onehot,
    output logic [11:0] display,
    output logic [1:0]  digit_count,
    output logic [1:0]  tries,
    output logic        lock_active,
    output logic        buzzer
);

    logic       digit_pulse;
    logic [3:0] digit_value;
    logic       enter_pulse;
    logic       clear_pulse;
    logic       cancel_pulse;
    logic       lock_start;
    logic       lock_abort;
    logic       lock_done;
    logic [7:0] lock_seconds;
    logic       chirp_pulse;
    logic       pass_pulse;
    logic       fail_pulse;

    key_decoder u_key_decoder (
        .clk          (clk),
        .rst          (rst),
        .onehot       (onehot),
        .digit_pulse  (digit_pulse),
        .digit_value  (digit_value),
        .enter_pulse  (enter_pulse),
        .clear_pulse  (clear_pulse),
        .cancel_pulse (cancel_pulse)
    );

    code_entry u_code_entry (
        .clk          (clk),
        .rst          (rst),
        .digit_pulse  (digit_pulse),
        .digit_value  (digit_value),
        .enter_pulse  (enter_pulse),
        .clear_pulse  (clear_pulse),
        .cancel_pulse (cancel_pulse),
        .lock_active  (lock_active),
        .lock_seconds (lock_seconds),
        .lock_done    (lock_done),
        .display      (display),
        .digit_count  (digit_count),
        .tries        (tries),
        .lock_start   (lock_start),
        .lock_abort   (lock_abort),
        .chirp_pulse  (chirp_pulse),
        .pass_pulse   (pass_pulse),
        .fail_pulse   (fail_pulse)
    );

    lockout_timer u_lockout_timer (
        .clk          (clk),
        .rst          (rst),
        .lock_start   (lock_start),
        .lock_abort   (lock_abort),
        .lock_active  (lock_active),
        .lock_seconds (lock_seconds),
        .lock_done    (lock_done)
    );

    buzzer_tone u_buzzer_tone (
        .clk          (clk),
        .rst          (rst),
        .chirp_pulse  (chirp_pulse),
        .pass_pulse   (pass_pulse),
        .fail_pulse   (fail_pulse),
        .buzzer       (buzzer)
    );

endmodule

// ==== buzzer_tone.sv ====
module buzzer_tone (
    input  logic clk,
    input  logic rst,
    input  logic chirp_pulse,
    input  logic pass_pulse,
    input  logic fail_pulse,
    output logic buzzer
);
    import lock_pkg::*;

    logic        active;
    logic        fail_mode;
    logic        start;
    logic        in_gap;
    logic [31:0] half_limit;
    logic [31:0] len_limit;
    logic [31:0] half_count;
    logic [31:0] len_count;

    assign start  = chirp_pulse || pass_pulse || fail_pulse;
    assign in_gap = fail_mode && (len_count >= FAIL_GAP_LO) && (len_count < FAIL_GAP_HI);

    // pattern select, fail over pass over chirp
    always_ff @(posedge clk) begin
        if (fail_pulse) begin
            half_limit <= FAIL_HALF;
            len_limit  <= FAIL_LEN;
        end else if (pass_pulse) begin
            half_limit <= PASS_HALF;
            len_limit  <= PASS_LEN;
        end else if (chirp_pulse) begin
            half_limit <= CHIRP_HALF;
            len_limit  <= CHIRP_LEN;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active     <= 1'b0;
            fail_mode  <= 1'b0;
            half_count <= 32'd0;
            len_count  <= 32'd0;
            buzzer     <= 1'b0;
        end else if (start) begin
            active     <= 1'b1;  // restart on any new pulse
            fail_mode  <= fail_pulse;
            half_count <= 32'd0;
            len_count  <= 32'd0;
            buzzer     <= 1'b1;
        end else if (active) begin
            len_count <= len_count + 32'd1;
            if (half_count == half_limit - 32'd1) begin
                half_count <= 32'd0;
                buzzer     <= ~buzzer;
            end else begin
                half_count <= half_count + 32'd1;
            end
            if (in_gap) begin
                buzzer <= 1'b0;  // broken part of the fail tone
            end
            if (len_count == len_limit - 32'd1) begin
                active    <= 1'b0;
                fail_mode <= 1'b0;
                buzzer    <= 1'b0;
            end
        end else begin
            buzzer <= 1'b0;
        end
    end

endmodule

// ==== lockout_timer.sv ====
module lockout_timer (
    input  logic       clk,
    input  logic       rst,
    input  logic       lock_start,
    input  logic       lock_abort,
    output logic       lock_active,
    output logic [7:0] lock_seconds,
    output logic       lock_done
);
    import lock_pkg::*;

    logic [31:0] tick_count;
    logic [3:0]  sec_tens;
    logic [3:0]  sec_units;
    logic [3:0]  next_tens;
    logic [3:0]  next_units;
    logic        tick;
    logic        at_end;

    assign tick       = (tick_count == SECOND_CYCLES - 32'd1);
    assign next_units = (sec_units == 4'd9) ? 4'd0 : sec_units + 4'd1;
    assign next_tens  = (sec_units == 4'd9) ? sec_tens + 4'd1 : sec_tens;

    // the step that would show the full lockout length ends it
    assign at_end = ({next_tens, next_units} ==
                     {4'(LOCKOUT_SECONDS / 10), 4'(LOCKOUT_SECONDS % 10)});

    assign lock_seconds = {sec_tens, sec_units};

    always_ff @(posedge clk) begin
        if (rst) begin
            lock_active <= 1'b0;
            lock_done   <= 1'b0;
            tick_count  <= 32'd0;
            sec_tens    <= 4'd0;
            sec_units   <= 4'd0;
        end else begin
            lock_done <= 1'b0;
            if (lock_abort || lock_start) begin
                lock_active <= !lock_abort;  // abort wins
                tick_count  <= 32'd0;
                sec_tens    <= 4'd0;
                sec_units   <= 4'd0;
            end else if (lock_active) begin
                if (!tick) begin
                    tick_count <= tick_count + 32'd1;
                end else if (at_end) begin
                    tick_count  <= 32'd0;
                    lock_active <= 1'b0;
                    lock_done   <= 1'b1;
                    sec_tens    <= 4'd0;
                    sec_units   <= 4'd0;
                end else begin
                    tick_count <= 32'd0;
                    sec_tens   <= next_tens;
                    sec_units  <= next_units;
                end
            end
        end
    end

endmodule

// ==== code_entry.sv ====
module code_entry (
    input  logic        clk,
    input  logic        rst,
    input  logic        digit_pulse,
    input  logic [3:0]  digit_value,
    input  logic        enter_pulse,
    input  logic        clear_pulse,
    input  logic        cancel_pulse,
    input  logic        lock_active,
    input  logic [7:0]  lock_seconds,
    input  logic        lock_done,
    output logic [11:0] display,
    output logic [1:0]  digit_count,
    output logic [1:0]  tries,
    output logic        lock_start,
    output logic        lock_abort,
    output logic        chirp_pulse,
    output logic        pass_pulse,
    output logic        fail_pulse
);
    import lock_pkg::*;

    logic [11:0] entry;
    logic        locked;
    logic        pass_shown;
    logic        entry_full;
    logic [1:0]  tries_next;

    assign locked     = lock_active || lock_start;  // covers the cycle before the timer starts
    assign pass_shown = (entry == DISPLAY_PASS);
    assign entry_full = (digit_count == 2'd3);
    assign tries_next = tries + 2'd1;

    // clear reaches the timer in the same cycle it reaches the entry
    assign lock_abort = clear_pulse;

    // lockout shows 0 over the BCD seconds
    assign display = locked ? {4'h0, lock_seconds} : entry;

    always_ff @(posedge clk) begin
        if (rst) begin
            entry       <= DISPLAY_BLANK;
            digit_count <= 2'd0;
            tries       <= 2'd0;
            lock_start  <= 1'b0;
            chirp_pulse <= 1'b0;
            pass_pulse  <= 1'b0;
            fail_pulse  <= 1'b0;
        end else begin
            lock_start  <= 1'b0;
            chirp_pulse <= 1'b0;
            pass_pulse  <= 1'b0;
            fail_pulse  <= 1'b0;

            if (clear_pulse) begin
                entry       <= DISPLAY_BLANK;
                digit_count <= 2'd0;
                tries       <= 2'd0;
            end else if (lock_done) begin
                entry       <= DISPLAY_BLANK;  // lockout over, start fresh
                digit_count <= 2'd0;
                tries       <= 2'd0;
            end else if (cancel_pulse) begin
                entry       <= DISPLAY_BLANK;
                digit_count <= 2'd0;
            end else if (enter_pulse && !locked && !pass_shown && entry_full) begin
                if (entry == SECRET_CODE) begin
                    entry      <= DISPLAY_PASS;
                    pass_pulse <= 1'b1;
                end else begin
                    entry       <= DISPLAY_BLANK;
                    digit_count <= 2'd0;
                    tries       <= tries_next;
                    fail_pulse  <= 1'b1;
                    if (tries_next == MAX_TRIES) begin
                        lock_start <= 1'b1;  // third miss
                    end
                end
            end else if (digit_pulse && !locked && !pass_shown && !entry_full) begin
                entry       <= {entry[7:0], digit_value};  // shift in from the right
                digit_count <= digit_count + 2'd1;
                chirp_pulse <= 1'b1;
            end
        end
    end

endmodule

// ==== key_decoder.sv ====
module key_decoder (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] onehot,
    output logic        digit_pulse,
    output logic [3:0]  digit_value,
    output logic        enter_pulse,
    output logic        clear_pulse,
    output logic        cancel_pulse
);
    import lock_pkg::*;

    logic [15:0] prev_onehot;
    logic        key_changed;
    logic        digit_hit;
    logic [3:0]  digit_idx;

    // new press only, release to no key gives nothing
    assign key_changed = (onehot != prev_onehot) && (onehot != KEY_NONE);

    // look the word up in the digit table
    always_comb begin
        digit_hit = 1'b0;
        digit_idx = 4'd0;
        for (int i = 0; i < $size(DIGIT_KEYS); i++) begin
            if (onehot == DIGIT_KEYS[i]) begin
                digit_hit = 1'b1;
                digit_idx = 4'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prev_onehot  <= KEY_NONE;
            digit_pulse  <= 1'b0;
            enter_pulse  <= 1'b0;
            clear_pulse  <= 1'b0;
            cancel_pulse <= 1'b0;
        end else begin
            prev_onehot  <= onehot;
            digit_pulse  <= key_changed && digit_hit;
            enter_pulse  <= key_changed && (onehot == KEY_ENTER);
            clear_pulse  <= key_changed && (onehot == KEY_CLEAR);
            cancel_pulse <= key_changed && (onehot == KEY_CANCEL);
        end
    end

    always_ff @(posedge clk) begin
        digit_value <= digit_idx;  // only read with digit_pulse
    end

endmodule

// ==== lock_pkg.sv ====
package lock_pkg;

    // keypad command keys, one-hot
    localparam logic [15:0] KEY_ENTER  = 16'h0001;
    localparam logic [15:0] KEY_CLEAR  = 16'h0100;
    localparam logic [15:0] KEY_CANCEL = 16'h1000;
    localparam logic [15:0] KEY_NONE   = 16'h0000;

    // keypad word per digit, index is the digit value
    localparam logic [15:0] DIGIT_KEYS [0:9] = '{
        16'h0008,  // 0
        16'h0080,  // 1
        16'h0040,  // 2
        16'h0020,  // 3
        16'h0800,  // 4
        16'h0400,  // 5
        16'h0200,  // 6
        16'h8000,  // 7
        16'h4000,  // 8
        16'h2000   // 9
    };

    localparam logic [3:0]  NIBBLE_BLANK  = 4'hF;
    localparam logic [11:0] DISPLAY_BLANK = {3{NIBBLE_BLANK}};
    localparam logic [11:0] DISPLAY_PASS  = 12'hBCC;  // "ASS" of PASS
    localparam logic [11:0] SECRET_CODE   = 12'h246;
    localparam logic [1:0]  MAX_TRIES     = 2'd3;

    localparam int          LOCKOUT_SECONDS = 60;
    localparam logic [31:0] SECOND_CYCLES   = 32'd50;  // sim scale, board uses clock rate

    // buzzer patterns, all in clocks
    localparam logic [31:0] CHIRP_HALF  = 32'd5;
    localparam logic [31:0] CHIRP_LEN   = 32'd200;
    localparam logic [31:0] PASS_HALF   = 32'd3;
    localparam logic [31:0] PASS_LEN    = 32'd600;
    localparam logic [31:0] FAIL_HALF   = 32'd10;
    localparam logic [31:0] FAIL_LEN    = 32'd300;
    localparam logic [31:0] FAIL_GAP_LO = 32'd100;
    localparam logic [31:0] FAIL_GAP_HI = 32'd200;

endpackage
